//--- src.f
+incdir+.
panel_pkg.sv
lcd_pkg.sv
led_driver.sv
seg_scanner.sv
lcd_message_rom.sv
lcd_sequencer.sv
score_board_top.sv
tb_score_board.sv

//--- Makefile
SIM       := verilator
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_score_board
FILELIST  := src.f
BUILD     := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_score_board.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module tb_score_board;
    import panel_pkg::*;
    import lcd_pkg::*;

    localparam int clk_period = 4;
    localparam int power_len = `LCD_WAIT_POWER + 1;
    localparam int cmd_len = `LCD_WAIT_CMD + 1;
    localparam int line_len = `LCD_WAIT_LINE + 1;
    localparam int home_len = `LCD_WAIT_HOME + 1;
    localparam int clear_len = `LCD_WAIT_CLEAR + 1;
    localparam int init_len = power_len + 3 * cmd_len;
    localparam int loop_len = 2 * line_len + home_len + clear_len;
    localparam int run_cycles = init_len + 3 * loop_len; // Init plus three message loops
    localparam int watchdog_cycles = run_cycles + 4 + 200;

    logic clk = 1'b0; // Starts low without an edge
    logic rst;
    logic [1:0] c_value1;
    logic [1:0] c_value2;
    logic [2:0] score1;
    logic [2:0] score2;
    logic [1:0] winner;
    led_rgb_t led1;
    led_rgb_t led2;
    seg_scan_t seg_out;
    lcd_bus_t lcd;

    integer seed;
    int errors;
    int checks;
    int model_pos; // Own copy of the scan position
    int lcd_idx; // Cycles since reset release
    int stim_idx;
    string line_text;

    // Inputs as the DUT saw them at the last edge
    logic prev_rst;
    logic [1:0] prev_c1;
    logic [1:0] prev_c2;
    logic [2:0] prev_s1;
    logic [2:0] prev_s2;
    logic [1:0] prev_win;

    score_board_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .c_value1 (c_value1),
        .c_value2 (c_value2),
        .score1   (score1),
        .score2   (score2),
        .winner   (winner),
        .led1     (led1),
        .led2     (led2),
        .seg_out  (seg_out),
        .lcd      (lcd)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic led_rgb_t led_ref(input logic [1:0] code);
        led_rgb_t rgb;
        rgb = '0;
        if (code == 2'b01) rgb.r = 1'b1;
        if (code == 2'b10) rgb.g = 1'b1;
        if (code == 2'b11) rgb.b = 1'b1;
        return rgb;
    endfunction

    // Segments a to g, MSB first
    function automatic logic [6:0] seg_ref(input logic [2:0] score);
        case (score)
            3'd1:    return 7'b0110000; // b c
            3'd2:    return 7'b1101101; // a b d e g
            3'd3:    return 7'b1111001; // a b c d g
            3'd4:    return 7'b0110011; // b c f g
            3'd5:    return 7'b1011011; // a c d f g
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic logic [7:0] lcd_char_ref(input logic [1:0] win, input int line,
                                                 input int col);
        string text;
        if (col < 1 || col > 9 || !(win == 2'b01 || win == 2'b10)) return 8'h20;
        if (line == 1) begin
            text = (win == 2'b01) ? " P1 Win  " : " P2 Win  ";
            return text.getc(col - 1);
        end
        if (col == 1 || col == 5 || col == 9) return 8'h20;
        return 8'h9D; // Heart glyph
    endfunction

    function automatic lcd_bus_t command_bus(input logic [7:0] code);
        lcd_bus_t bus;
        bus.rs = 1'b0;
        bus.rw = 1'b0;
        bus.data = code;
        return bus;
    endfunction

    function automatic lcd_bus_t text_bus(input logic [7:0] code);
        lcd_bus_t bus;
        bus.rs = 1'b1;
        bus.rw = 1'b0;
        bus.data = code;
        return bus;
    endfunction

    // Expected bus for the state at a given cycle after reset release
    function automatic lcd_bus_t lcd_ref(input int idx, input logic [1:0] win);
        lcd_bus_t bus;
        int j;
        int k;
        bus.rs = 1'b1;
        bus.rw = 1'b1;
        bus.data = 8'h00;
        if (idx < power_len) return bus;
        j = idx - power_len;
        if (j < cmd_len) return command_bus(8'h3C);
        if (j < 2 * cmd_len) return command_bus(8'h06);
        if (j < 3 * cmd_len) return command_bus(8'h0C);
        k = (idx - init_len) % loop_len;
        if (k == 0) return command_bus(8'h80);
        if (k < line_len) return text_bus(lcd_char_ref(win, 1, k));
        if (k == line_len) return command_bus(8'hC0);
        if (k < 2 * line_len) return text_bus(lcd_char_ref(win, 2, k - line_len));
        if (k < 2 * line_len + home_len) return command_bus(8'h02);
        return command_bus(8'h01);
    endfunction

    function automatic bit in_line_state(input int idx);
        if (idx < init_len) return 1'b0;
        return ((idx - init_len) % loop_len) < 2 * line_len;
    endfunction

    function automatic logic [1:0] loop_winner(input int idx);
        case ((idx - init_len) / loop_len)
            0:       return 2'b01;
            1:       return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic string line1_text(input int loop_num);
        case (loop_num)
            0:       return " P1 Win  ";
            1:       return " P2 Win  ";
            default: return "         ";
        endcase
    endfunction

    // Negative index means reset is still active
    task automatic drive_inputs(input int idx);
        c_value1 = 2'($random(seed));
        c_value2 = 2'($random(seed));
        score1 = 3'($random(seed));
        score2 = 3'($random(seed));
        if (idx >= 0 && in_line_state(idx)) begin
            winner = loop_winner(idx); // Held through both line states
        end else begin
            winner = 2'($random(seed));
        end
    endtask

    always @(negedge clk) begin : compare_outputs
        led_rgb_t exp_led1;
        led_rgb_t exp_led2;
        seg_scan_t exp_seg;
        lcd_bus_t exp_lcd;
        int k;
        if (!prev_rst) begin
            exp_led1 = '0;
            exp_led2 = '0;
            exp_seg = '0;
            exp_lcd = command_bus(8'h00);
            exp_lcd.rs = 1'b1;
            exp_lcd.rw = 1'b1;
            model_pos = 0;
            lcd_idx = 0;
            line_text = "";
        end else begin
            exp_led1 = led_ref(prev_c1);
            exp_led2 = led_ref(prev_c2);
            exp_seg.pos = `SEG_DIGITS'(1) << model_pos;
            if (model_pos == 0) begin
                exp_seg.segs = seg_ref(prev_s1);
            end else if (model_pos == `SEG_DIGITS - 1) begin
                exp_seg.segs = seg_ref(prev_s2);
            end else begin
                exp_seg.segs = '0;
            end
            exp_lcd = lcd_ref(lcd_idx, prev_win);
            if (lcd_idx >= init_len) begin
                k = (lcd_idx - init_len) % loop_len;
                if (k >= 1 && k < `LCD_LINE_CHARS) begin
                    line_text = $sformatf("%s%c", line_text, lcd.data); // Decoded text
                end
                if (k == `LCD_LINE_CHARS - 1) begin
                    if (line_text != line1_text((lcd_idx - init_len) / loop_len)) begin
                        $display("[ERROR] %0t line 1 text expected '%s' got '%s'", $time,
                                 line1_text((lcd_idx - init_len) / loop_len), line_text);
                        errors++;
                    end
                    line_text = "";
                end
            end
            checks++;
            if ($countones(seg_out.pos) != 1) begin
                $display("Scan position is not one-hot at %0t: %b", $time, seg_out.pos);
                errors++;
            end
            model_pos = (model_pos + 1) % `SEG_DIGITS;
            lcd_idx++;
        end
        checks += 4;
        if (led1 !== exp_led1) begin
            $display("[ERROR] %0t led1 expected %b got %b", $time, exp_led1, led1);
            errors++;
        end
        if (led2 !== exp_led2) begin
            $display("[ERROR] %0t led2 expected %b got %b", $time, exp_led2, led2);
            errors++;
        end
        if (seg_out !== exp_seg) begin
            $display("[ERROR] %0t seg_out expected %h got %h", $time, exp_seg, seg_out);
            errors++;
        end
        if (lcd !== exp_lcd) begin
            $display("[ERROR] %0t lcd expected %h got %h", $time, exp_lcd, lcd);
            errors++;
        end
        prev_rst = rst;
        prev_c1 = c_value1;
        prev_c2 = c_value2;
        prev_s1 = score1;
        prev_s2 = score2;
        prev_win = winner;
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed = 32'h551d;
        errors = 0;
        checks = 0;
        model_pos = 0;
        lcd_idx = 0;
        line_text = "";
        prev_rst = 1'b0;
        prev_c1 = '0;
        prev_c2 = '0;
        prev_s1 = '0;
        prev_s2 = '0;
        prev_win = '0;
        rst = 1'b0;
        c_value1 = '0;
        c_value2 = '0;
        score1 = '0;
        score2 = '0;
        winner = '0;
        repeat (3) begin
            @(posedge clk);
            #1;
            drive_inputs(-1);
        end
        @(posedge clk);
        #1;
        rst = 1'b1; // Released after four reset edges
        for (stim_idx = 0; stim_idx < run_cycles; stim_idx++) begin
            drive_inputs(stim_idx);
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        #1;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- score_board_top.sv
`timescale 1ns/1ps

module score_board_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           c_value1,
    input  logic [1:0]           c_value2,
    input  logic [2:0]           score1,
    input  logic [2:0]           score2,
    input  logic [1:0]           winner,
    output panel_pkg::led_rgb_t  led1,
    output panel_pkg::led_rgb_t  led2,
    output panel_pkg::seg_scan_t seg_out,
    output lcd_pkg::lcd_bus_t    lcd
);

    // Player colour LEDs
    led_driver led_i (
        .clk      (clk),
        .rst      (rst),
        .c_value1 (c_value1),
        .c_value2 (c_value2),
        .led1     (led1),
        .led2     (led2)
    );

    // Score digits at both ends of the panel
    seg_scanner seg_i (
        .clk     (clk),
        .rst     (rst),
        .score1  (score1),
        .score2  (score2),
        .seg_out (seg_out)
    );

    lcd_sequencer lcd_i (
        .clk    (clk),
        .rst    (rst),
        .winner (winner),
        .lcd    (lcd)
    );

endmodule

//--- lcd_sequencer.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module lcd_sequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        winner,
    output lcd_pkg::lcd_bus_t lcd
);
    import lcd_pkg::*;

    // Sized for the longest interval
    localparam int cnt_bits = $clog2(`LCD_WAIT_HOME + 1);

    lcd_state_t state;
    logic [cnt_bits-1:0] count;
    lcd_line_t line;
    logic [7:0] glyph;

    function automatic logic [cnt_bits-1:0] wait_last(input lcd_state_t s);
        logic [cnt_bits-1:0] last;
        case (s)
            power_wait:               last = cnt_bits'(`LCD_WAIT_POWER);
            write_line1, write_line2: last = cnt_bits'(`LCD_WAIT_LINE);
            return_home:              last = cnt_bits'(`LCD_WAIT_HOME);
            clear_display:            last = cnt_bits'(`LCD_WAIT_CLEAR);
            default:                  last = cnt_bits'(`LCD_WAIT_CMD);
        endcase
        return last;
    endfunction

    function automatic lcd_state_t next_state(input lcd_state_t s);
        lcd_state_t nxt;
        case (s)
            power_wait:    nxt = function_set;
            function_set:  nxt = entry_mode;
            entry_mode:    nxt = display_on;
            display_on:    nxt = write_line1;
            write_line1:   nxt = write_line2;
            write_line2:   nxt = return_home;
            return_home:   nxt = clear_display;
            default:       nxt = write_line1; // Message loop restarts
        endcase
        return nxt;
    endfunction

    function automatic lcd_bus_t cmd_bus(input lcd_cmd_t cmd);
        lcd_bus_t bus;
        bus.rs   = 1'b0;
        bus.rw   = 1'b0;
        bus.data = cmd;
        return bus;
    endfunction

    assign line = (state == write_line2) ? line_two : line_one;

    lcd_message_rom rom_i (
        .winner (winner),
        .line   (line),
        .column (count[3:0]),
        .glyph  (glyph)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= power_wait;
            count <= '0;
        end else if (count == wait_last(state)) begin
            state <= next_state(state);
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Bus follows the state one cycle later
    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd <= bus_idle;
        end else begin
            case (state)
                function_set:  lcd <= cmd_bus(cmd_function_set);
                entry_mode:    lcd <= cmd_bus(cmd_entry_mode);
                display_on:    lcd <= cmd_bus(cmd_display_on);
                return_home:   lcd <= cmd_bus(cmd_home);
                clear_display: lcd <= cmd_bus(cmd_clear);
                write_line1, write_line2: begin
                    if (count == '0) begin
                        lcd <= cmd_bus((state == write_line1) ? cmd_line1_addr
                                                              : cmd_line2_addr);
                    end else begin
                        lcd.rs   <= 1'b1;
                        lcd.rw   <= 1'b0;
                        lcd.data <= (count < `LCD_LINE_CHARS) ? glyph : char_space;
                    end
                end
                default:       lcd <= bus_idle; // Still powering up
            endcase
        end
    end

endmodule

//--- lcd_message_rom.sv
`timescale 1ns/1ps

module lcd_message_rom (
    input  logic                [1:0] winner,
    input  lcd_pkg::lcd_line_t        line,
    input  logic                [3:0] column,
    output logic                [7:0] glyph
);
    import lcd_pkg::*;

    logic has_winner;

    assign has_winner = (winner == 2'b01) || (winner == 2'b10);

    always_comb begin
        glyph = char_space;
        if (has_winner) begin
            if (line == line_one) begin
                case (column)
                    4'd2: glyph = "P";
                    4'd3: glyph = (winner == 2'b01) ? "1" : "2";
                    4'd5: glyph = "W";
                    4'd6: glyph = "i";
                    4'd7: glyph = "n";
                    default: glyph = char_space;
                endcase
            end else begin
                // Two groups of three hearts
                case (column)
                    4'd2, 4'd3, 4'd4: glyph = char_heart;
                    4'd6, 4'd7, 4'd8: glyph = char_heart;
                    default: glyph = char_space;
                endcase
            end
        end
    end

endmodule

//--- seg_scanner.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module seg_scanner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [2:0]           score1,
    input  logic [2:0]           score2,
    output panel_pkg::seg_scan_t seg_out
);
    import panel_pkg::*;

    localparam int pos_bits = $clog2(`SEG_DIGITS);
    localparam logic [pos_bits-1:0] last_pos = pos_bits'(`SEG_DIGITS - 1);

    logic [pos_bits-1:0] pos_cnt;
    logic [`SEG_WIDTH-1:0] pattern;

    // Segment order a to g, MSB first
    function automatic logic [`SEG_WIDTH-1:0] score_glyph(input logic [2:0] score);
        logic [`SEG_WIDTH-1:0] glyph;
        case (score)
            3'd1:    glyph = 7'b0110000;
            3'd2:    glyph = 7'b1101101;
            3'd3:    glyph = 7'b1111001;
            3'd4:    glyph = 7'b0110011;
            3'd5:    glyph = 7'b1011011;
            default: glyph = 7'b0000000; // Out of range, blank
        endcase
        return glyph;
    endfunction

    // Player 1 on the leftmost digit, player 2 on the rightmost
    always_comb begin
        if (pos_cnt == '0) begin
            pattern = score_glyph(score1);
        end else if (pos_cnt == last_pos) begin
            pattern = score_glyph(score2);
        end else begin
            pattern = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pos_cnt <= '0;
            seg_out <= '0; // No digit selected
        end else begin
            pos_cnt      <= pos_cnt + 1'b1; // Wraps after the last digit
            seg_out.pos  <= `SEG_DIGITS'(1) << pos_cnt;
            seg_out.segs <= pattern;
        end
    end

endmodule

//--- led_driver.sv
`timescale 1ns/1ps

module led_driver (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          c_value1,
    input  logic [1:0]          c_value2,
    output panel_pkg::led_rgb_t led1,
    output panel_pkg::led_rgb_t led2
);
    import panel_pkg::*;

    function automatic led_rgb_t decode_colour(input logic [1:0] code);
        led_rgb_t rgb;
        rgb = '0;
        case (led_colour_t'(code))
            colour_red:   rgb.r = 1'b1;
            colour_green: rgb.g = 1'b1;
            colour_blue:  rgb.b = 1'b1;
            default:      rgb = '0; // LED dark
        endcase
        return rgb;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst) begin
            led1 <= '0;
            led2 <= '0;
        end else begin
            led1 <= decode_colour(c_value1);
            led2 <= decode_colour(c_value2);
        end
    end

endmodule

//--- lcd_pkg.sv
package lcd_pkg;

    // Sequencer states, in the order they are visited
    typedef enum logic [2:0] {
        power_wait,
        function_set,
        entry_mode,
        display_on,
        write_line1,
        write_line2,
        return_home,
        clear_display
    } lcd_state_t;

    // Controller command bytes
    typedef enum logic [7:0] {
        cmd_clear        = 8'h01,
        cmd_home         = 8'h02,
        cmd_entry_mode   = 8'h06,
        cmd_display_on   = 8'h0C,
        cmd_function_set = 8'h3C, // 8-bit bus, two lines, 5x11 font
        cmd_line1_addr   = 8'h80,
        cmd_line2_addr   = 8'hC0
    } lcd_cmd_t;

    typedef enum logic {
        line_one = 1'b0,
        line_two = 1'b1
    } lcd_line_t;

    typedef struct packed {
        logic       rs; // 1 for character data
        logic       rw;
        logic [7:0] data;
    } lcd_bus_t;

    localparam logic [7:0] char_space = 8'h20;
    localparam logic [7:0] char_heart = 8'h9D; // Heart in the CGROM

    // Bus level while the panel powers up
    localparam lcd_bus_t bus_idle = '{rs: 1'b1, rw: 1'b1, data: 8'h00};

endpackage

//--- panel_pkg.sv
`include "game_defs.svh"

package panel_pkg;

    // Colour code from the game logic
    typedef enum logic [1:0] {
        colour_off   = 2'b00,
        colour_red   = 2'b01,
        colour_green = 2'b10,
        colour_blue  = 2'b11
    } led_colour_t;

    // One RGB LED, active high
    typedef struct packed {
        logic r;
        logic g;
        logic b;
    } led_rgb_t;

    // Multiplexed seven-segment output
    typedef struct packed {
        logic [`SEG_WIDTH-1:0]  segs; // Pattern in a-to-g order
        logic [`SEG_DIGITS-1:0] pos; // One-hot digit select
    } seg_scan_t;

endpackage

//--- game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Seven-segment panel geometry
`define SEG_DIGITS 8 // Scanned digit positions
`define SEG_WIDTH 7 // Segments a to g

// LCD interval counts
// Each value is the last count of its state, so a state
// lasts the value plus one clock cycles
`define LCD_WAIT_POWER 70 // Power-up settle time
`define LCD_WAIT_CMD 30 // Function set, entry mode, display on
`define LCD_WAIT_LINE 20 // One line of text
`define LCD_WAIT_HOME 400 // Return home is slow on the controller
`define LCD_WAIT_CLEAR 200 // Clear display

// Text columns per line
// Column 0 carries the DDRAM address command
`define LCD_LINE_CHARS 10

`endif
